// ==== cgra_tile.f ====
+incdir+hdl
hdl/cgra_pkg.sv
hdl/alu.sv
hdl/reg_unit.sv
hdl/config_store.sv
hdl/cgra_tile.sv
test/cgra_tile_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

`include "cgra_cfg.svh"

module alu (
  input  logic [`CGRA_DATA_WIDTH-1:0] data_in1,
  input  logic [`CGRA_DATA_WIDTH-1:0] data_in2,
  input  logic [`CGRA_DATA_WIDTH-1:0] data_in3,
  input  logic [`CGRA_DATA_WIDTH-1:0] cfg_const,
  input  logic [`CGRA_DATA_WIDTH-1:0] reg_q,
  input  logic                        cfg_en,
  input  cgra_pkg::alu_op_e           cfg_op,
  input  cgra_pkg::left_sel_e         cfg_left_sel,
  input  cgra_pkg::right_sel_e        cfg_right_sel,
  output logic [`CGRA_DATA_WIDTH-1:0] alu_result
);

  import cgra_pkg::*;

  logic [`CGRA_DATA_WIDTH-1:0] left_op;
  logic [`CGRA_DATA_WIDTH-1:0] right_op;

  // ##########################################################
  // operand selection
  // ##########################################################

  always_comb begin
    case (cfg_left_sel)
      LEFT_CONST: left_op = cfg_const;
      default:    left_op = data_in1;
    endcase
  end

  always_comb begin
    case (cfg_right_sel)
      RIGHT_IN3:      right_op = data_in3;
      RIGHT_CONST:    right_op = cfg_const;
      RIGHT_FEEDBACK: right_op = reg_q;     // always the register, never the bypass path.
      default:        right_op = data_in2;
    endcase
  end

  // ##########################################################
  // operation
  // ##########################################################

  always_comb begin
    if (!cfg_en) begin
      alu_result = '0;
    end else begin
      case (cfg_op)
        OP_ADD: begin
          alu_result = left_op + right_op;   // wraps at the data width.
        end
        OP_SUB: begin
          alu_result = left_op - right_op;
        end
        OP_AND: begin
          alu_result = left_op & right_op;
        end
        OP_OR: begin
          alu_result = left_op | right_op;
        end
        OP_XOR: begin
          alu_result = left_op ^ right_op;
        end
        OP_MUL: begin
          alu_result = left_op * right_op;   // only the low byte of the product is kept.
        end
        default: begin
          alu_result = '0;
        end
      endcase
    end
  end

endmodule

// ==== hdl/cgra_cfg.svh ====
`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// ##########################################################
// widths
// ##########################################################

`define CGRA_DATA_WIDTH 8        // fabric data bus.
`define CGRA_AXI_ADDR_WIDTH 8
`define CGRA_AXI_DATA_WIDTH 32

// ##########################################################
// register map, one 32-bit word per register
// ##########################################################

`define CGRA_REG_CTRL 8'h00      // bit 0 enables the tile.
`define CGRA_REG_OP 8'h04        // bits 2:0 opcode.
`define CGRA_REG_SEL 8'h08       // bit 0 left select, bits 2:1 right select.
`define CGRA_REG_CONST 8'h0C     // bits 7:0 constant operand.
`define CGRA_REG_MODE 8'h10      // bit 0 selects bypass.
`define CGRA_REG_RESULT 8'h14    // read only, live tile output.

`endif

// ==== hdl/cgra_pkg.sv ====
package cgra_pkg;

  // ##########################################################
  // datapath encodings
  // ##########################################################

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5   // codes 6 and 7 are undefined and give 0.
  } alu_op_e;

  typedef enum logic {
    LEFT_IN1   = 1'b0,
    LEFT_CONST = 1'b1
  } left_sel_e;

  typedef enum logic [1:0] {
    RIGHT_IN2      = 2'd0,
    RIGHT_IN3      = 2'd1,
    RIGHT_CONST    = 2'd2,
    RIGHT_FEEDBACK = 2'd3   // registered result, used for accumulation.
  } right_sel_e;

  // ##########################################################
  // host bus
  // ##########################################################

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== hdl/cgra_tile.sv ====
`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_tile (
  input  logic                              clk,
  input  logic                              rst,
  // fabric data
  input  logic [`CGRA_DATA_WIDTH-1:0]       data_in1,
  input  logic [`CGRA_DATA_WIDTH-1:0]       data_in2,
  input  logic [`CGRA_DATA_WIDTH-1:0]       data_in3,
  output logic [`CGRA_DATA_WIDTH-1:0]       data_out,
  // host write channels
  input  logic [`CGRA_AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [`CGRA_AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [`CGRA_AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic                              bvalid,
  input  logic                              bready,
  output cgra_pkg::axi_resp_e               bresp,
  // host read channels
  input  logic [`CGRA_AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [`CGRA_AXI_DATA_WIDTH-1:0]   rdata,
  output cgra_pkg::axi_resp_e               rresp
);

  import cgra_pkg::*;

  logic                        cfg_en;
  logic                        cfg_bypass;
  alu_op_e                     cfg_op;
  left_sel_e                   cfg_left_sel;
  right_sel_e                  cfg_right_sel;
  logic [`CGRA_DATA_WIDTH-1:0] cfg_const;
  logic [`CGRA_DATA_WIDTH-1:0] alu_result;
  logic [`CGRA_DATA_WIDTH-1:0] reg_q;

  config_store config_store_inst (
    .clk           (clk),
    .rst           (rst),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .rresp         (rresp),
    .tile_out      (data_out),   // readback of the live output.
    .cfg_en        (cfg_en),
    .cfg_bypass    (cfg_bypass),
    .cfg_op        (cfg_op),
    .cfg_left_sel  (cfg_left_sel),
    .cfg_right_sel (cfg_right_sel),
    .cfg_const     (cfg_const)
  );

  alu alu_inst (
    .data_in1      (data_in1),
    .data_in2      (data_in2),
    .data_in3      (data_in3),
    .cfg_const     (cfg_const),
    .reg_q         (reg_q),
    .cfg_en        (cfg_en),
    .cfg_op        (cfg_op),
    .cfg_left_sel  (cfg_left_sel),
    .cfg_right_sel (cfg_right_sel),
    .alu_result    (alu_result)
  );

  reg_unit #(
    .WIDTH (`CGRA_DATA_WIDTH)
  ) reg_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .en      (cfg_en),
    .bypass  (cfg_bypass),
    .reg_in  (alu_result),
    .reg_q   (reg_q),
    .reg_out (data_out)
  );

endmodule

// ==== hdl/config_store.sv ====
`timescale 1ns/1ps

`include "cgra_cfg.svh"

module config_store (
  input  logic                            clk,
  input  logic                            rst,
  // write address and data
  input  logic [`CGRA_AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [`CGRA_AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [`CGRA_AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  // write response
  output logic                              bvalid,
  input  logic                              bready,
  output cgra_pkg::axi_resp_e               bresp,
  // read address and data
  input  logic [`CGRA_AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [`CGRA_AXI_DATA_WIDTH-1:0]   rdata,
  output cgra_pkg::axi_resp_e               rresp,
  // tile side
  input  logic [`CGRA_DATA_WIDTH-1:0]       tile_out,
  output logic                              cfg_en,
  output logic                              cfg_bypass,
  output cgra_pkg::alu_op_e                 cfg_op,
  output cgra_pkg::left_sel_e               cfg_left_sel,
  output cgra_pkg::right_sel_e              cfg_right_sel,
  output logic [`CGRA_DATA_WIDTH-1:0]       cfg_const
);

  import cgra_pkg::*;

  localparam int AXI_DW = `CGRA_AXI_DATA_WIDTH;
  localparam int AXI_SW = `CGRA_AXI_DATA_WIDTH / 8;

  logic              wr_accept;   // awready and wready, high for one cycle.
  logic              wr_hs;
  logic              wr_ok;
  logic              rd_hs;
  logic              rd_ok;
  logic [AXI_DW-1:0] rd_word;
  logic [AXI_DW-1:0] ctrl_next;
  logic [AXI_DW-1:0] op_next;
  logic [AXI_DW-1:0] sel_next;
  logic [AXI_DW-1:0] const_next;
  logic [AXI_DW-1:0] mode_next;

  // byte lanes with a strobe take the new data, the rest keep the old value.
  function automatic logic [AXI_DW-1:0] apply_strb(
    input logic [AXI_DW-1:0] cur,
    input logic [AXI_DW-1:0] data,
    input logic [AXI_SW-1:0] strb
  );
    logic [AXI_DW-1:0] merged;
    merged = cur;
    for (int i = 0; i < AXI_SW; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  // ##########################################################
  // write channels
  // ##########################################################

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign wr_hs   = wr_accept && awvalid && wvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_accept <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      wr_accept <= awvalid && wvalid && !bvalid && !wr_accept;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    case (awaddr)
      `CGRA_REG_CTRL, `CGRA_REG_OP, `CGRA_REG_SEL,
      `CGRA_REG_CONST, `CGRA_REG_MODE: wr_ok = 1'b1;
      default:                         wr_ok = 1'b0;   // RESULT is read only.
    endcase
  end

  assign ctrl_next  = apply_strb(AXI_DW'(cfg_en), wdata, wstrb);
  assign op_next    = apply_strb(AXI_DW'(cfg_op), wdata, wstrb);
  assign sel_next   = apply_strb(AXI_DW'({cfg_right_sel, cfg_left_sel}), wdata, wstrb);
  assign const_next = apply_strb(AXI_DW'(cfg_const), wdata, wstrb);
  assign mode_next  = apply_strb(AXI_DW'(cfg_bypass), wdata, wstrb);

  // ##########################################################
  // configuration fields
  // ##########################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_en        <= 1'b0;
      cfg_op        <= OP_ADD;
      cfg_left_sel  <= LEFT_IN1;
      cfg_right_sel <= RIGHT_IN2;
      cfg_const     <= '0;
      cfg_bypass    <= 1'b0;
    end else if (wr_hs) begin
      case (awaddr)
        `CGRA_REG_CTRL: begin
          cfg_en <= ctrl_next[0];
        end
        `CGRA_REG_OP: begin
          cfg_op <= alu_op_e'(op_next[2:0]);
        end
        `CGRA_REG_SEL: begin
          cfg_left_sel  <= left_sel_e'(sel_next[0]);
          cfg_right_sel <= right_sel_e'(sel_next[2:1]);
        end
        `CGRA_REG_CONST: begin
          cfg_const <= const_next[`CGRA_DATA_WIDTH-1:0];
        end
        `CGRA_REG_MODE: begin
          cfg_bypass <= mode_next[0];
        end
        default: begin
        end
      endcase
    end
  end

  // ##########################################################
  // read channels
  // ##########################################################

  assign arready = !rvalid;   // one outstanding read at a time.
  assign rd_hs   = arvalid && arready;

  always_comb begin
    rd_ok = 1'b1;
    case (araddr)
      `CGRA_REG_CTRL:   rd_word = AXI_DW'(cfg_en);
      `CGRA_REG_OP:     rd_word = AXI_DW'(cfg_op);
      `CGRA_REG_SEL:    rd_word = AXI_DW'({cfg_right_sel, cfg_left_sel});
      `CGRA_REG_CONST:  rd_word = AXI_DW'(cfg_const);
      `CGRA_REG_MODE:   rd_word = AXI_DW'(cfg_bypass);
      `CGRA_REG_RESULT: rd_word = AXI_DW'(tile_out);   // sampled live.
      default: begin
        rd_word = '0;
        rd_ok   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // rdata only loads on a handshake, so it stays put while rvalid waits.
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== hdl/reg_unit.sv ====
`timescale 1ns/1ps

`include "cgra_cfg.svh"

module reg_unit #(
  parameter int WIDTH = `CGRA_DATA_WIDTH
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  logic             bypass,
  input  logic [WIDTH-1:0] reg_in,
  output logic [WIDTH-1:0] reg_q,
  output logic [WIDTH-1:0] reg_out
);

  logic [WIDTH-1:0] result_q;

  // ##########################################################
  // result register
  // ##########################################################

  // The register keeps loading in bypass mode as well, so a tile that
  // accumulates through the feedback path works the same in either mode.
  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
    end else if (en) begin
      result_q <= reg_in;
    end
  end

  assign reg_q = result_q;   // feedback source.

  // ##########################################################
  // output select
  // ##########################################################

  always_comb begin
    if (bypass) begin
      reg_out = reg_in;    // zero latency.
    end else begin
      reg_out = result_q;  // one cycle of latency.
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cgra_tile testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
log_file="sim.log"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module cgra_tile_tb -Mdir "$build_dir" -o cgra_tile_sim \
  -f cgra_tile.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

"./$build_dir/cgra_tile_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== test/cgra_tile_tb.sv ====
`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_tile_tb;

  import cgra_pkg::*;

  localparam int NUM_FIXED   = 17;
  localparam int NUM_RANDOM  = 8;
  localparam int TIMEOUT_CYC = 50;

  logic                            clk;
  logic                            rst;
  logic [`CGRA_DATA_WIDTH-1:0]     data_in1, data_in2;
  logic [`CGRA_DATA_WIDTH-1:0]     data_in3, data_out;
  logic [`CGRA_AXI_ADDR_WIDTH-1:0] awaddr, araddr;
  logic [`CGRA_AXI_DATA_WIDTH-1:0] wdata, rdata;
  logic [3:0]                      wstrb;
  logic                            awvalid, awready, wvalid, wready, bvalid, bready;
  logic                            arvalid, arready, rvalid, rready;
  axi_resp_e                       bresp, rresp;

  // row layout is op, left sel, right sel, const, bypass, enable, in1, in2, in3, expected.
  logic [47:0] stim_table [0:NUM_FIXED-1];
  logic [15:0] lfsr_state;
  int          check_count;
  int          error_count;

  cgra_tile cgra_tile_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##########################################################
  // helpers
  // ##########################################################

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    error_count++;
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("closing: %0d checks, %0d errors", check_count, error_count);
    $display("STATUS: FAIL");
    $finish;
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // taps 16, 14, 13, 11.
  endfunction

  task automatic take_bits(input int n, output logic [7:0] bits);
    bits = 8'h00;
    for (int i = 0; i < n; i++) begin
      bits = {bits[6:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic [7:0] model_result(input logic [2:0] op, input logic lsel,
      input logic [1:0] rsel, input logic [7:0] cnst, input logic en, input logic [7:0] in1,
      input logic [7:0] in2, input logic [7:0] in3, input logic [7:0] fb);
    int a;
    int b;
    int r;
    a = lsel ? int'(cnst) : int'(in1);
    case (rsel)
      2'd0:    b = int'(in2);
      2'd1:    b = int'(in3);
      2'd2:    b = int'(cnst);
      default: b = int'(fb);
    endcase
    case (op)
      3'd0:    r = (a + b) % 256;
      3'd1:    r = (a - b + 256) % 256;
      3'd2:    r = a & b;
      3'd3:    r = a | b;
      3'd4:    r = a ^ b;
      3'd5:    r = (a * b) % 256;
      default: r = 0;
    endcase
    if (!en) r = 0;
    return 8'(r);
  endfunction

  task automatic to_drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic set_inputs(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
    data_in1 = a;
    data_in2 = b;
    data_in3 = c;
  endtask

  // ##########################################################
  // host bus
  // ##########################################################

  task automatic issue_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int cycles;
    cycles  = 0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) begin
      if (cycles == TIMEOUT_CYC) abort_on_timeout("awready and wready");
      cycles++;
      @(negedge clk);
    end
    to_drive_slot();   // the handshake edge has passed.
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic wait_bvalid(output axi_resp_e resp);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!bvalid) begin
      if (cycles == TIMEOUT_CYC) abort_on_timeout("bvalid");
      cycles++;
      @(negedge clk);
    end
    resp = bresp;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output axi_resp_e resp);
    bready = 1'b1;
    issue_write(addr, data, strb);
    wait_bvalid(resp);
    to_drive_slot();
    bready = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    axi_resp_e resp;
    axi_write(addr, data, 4'hF, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output axi_resp_e resp);
    int cycles;
    cycles  = 0;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) begin
      if (cycles == TIMEOUT_CYC) abort_on_timeout("arready");
      cycles++;
      @(negedge clk);
    end
    to_drive_slot();
    arvalid = 1'b0;
    rready  = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!rvalid) begin
      if (cycles == TIMEOUT_CYC) abort_on_timeout("rvalid");
      cycles++;
      @(negedge clk);
    end
    check_value("arready", 32'(arready), 32'h0);   // no new address while a response waits.
    data = rdata;
    resp = rresp;
    to_drive_slot();
    rready = 1'b0;
  endtask

  task automatic read_and_compare(input logic [7:0] addr, input logic [31:0] exp,
                                  input axi_resp_e exp_resp);
    logic [31:0] data;
    axi_resp_e   resp;
    axi_read(addr, data, resp);
    check_value("rdata", data, exp);
    check_value("rresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic apply_row(input logic [47:0] row);
    write_reg(`CGRA_REG_OP, 32'(row[47:45]));
    write_reg(`CGRA_REG_SEL, 32'({row[43:42], row[44]}));
    write_reg(`CGRA_REG_CONST, 32'(row[41:34]));
    write_reg(`CGRA_REG_MODE, 32'(row[33]));
    write_reg(`CGRA_REG_CTRL, 32'(row[32]));
    set_inputs(row[31:24], row[23:16], row[15:8]);
    if (!row[33]) @(posedge clk);   // registered mode shows the result after one edge.
    @(negedge clk);
    check_value("data_out", 32'(data_out), 32'(row[7:0]));
    to_drive_slot();
  endtask

  // ##########################################################
  // test sequence
  // ##########################################################

  initial begin
    logic [7:0]  r_op, r_lsel, r_rsel, r_cnst, r_byp, r_in1, r_in2, r_in3;
    logic [7:0]  acc;
    logic [31:0] data;
    axi_resp_e   resp;

    check_count = 0;
    error_count = 0;
    lfsr_state  = 16'd16;
    rst         = 1'b1;
    set_inputs(8'h00, 8'h00, 8'h00);
    {awaddr, wdata, wstrb, awvalid, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;

    stim_table[0]  = {3'd0, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h12, 8'h34, 8'h00, 8'h46};
    stim_table[1]  = {3'd0, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'hF0, 8'h20, 8'h00, 8'h10};
    stim_table[2]  = {3'd1, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h50, 8'h20, 8'h00, 8'h30};
    stim_table[3]  = {3'd1, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h10, 8'h20, 8'h00, 8'hF0};
    stim_table[4]  = {3'd2, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'hCC, 8'hAA, 8'h00, 8'h88};
    stim_table[5]  = {3'd3, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'hCC, 8'hAA, 8'h00, 8'hEE};
    stim_table[6]  = {3'd4, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'hCC, 8'hAA, 8'h00, 8'h66};
    stim_table[7]  = {3'd5, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h07, 8'h09, 8'h00, 8'h3F};
    stim_table[8]  = {3'd5, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h10, 8'h11, 8'h00, 8'h10};
    stim_table[9]  = {3'd6, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'h12, 8'h34, 8'h00, 8'h00};
    stim_table[10] = {3'd7, 1'b0, 2'd0, 8'h00, 1'b0, 1'b1, 8'hFF, 8'hFF, 8'h00, 8'h00};
    stim_table[11] = {3'd0, 1'b1, 2'd0, 8'h05, 1'b0, 1'b1, 8'h77, 8'h03, 8'h00, 8'h08};
    stim_table[12] = {3'd1, 1'b0, 2'd1, 8'h00, 1'b0, 1'b1, 8'h40, 8'h99, 8'h01, 8'h3F};
    stim_table[13] = {3'd4, 1'b0, 2'd2, 8'hFF, 1'b0, 1'b1, 8'h0F, 8'h55, 8'h66, 8'hF0};
    stim_table[14] = {3'd0, 1'b0, 2'd0, 8'h00, 1'b1, 1'b1, 8'h21, 8'h13, 8'h00, 8'h34};
    stim_table[15] = {3'd5, 1'b0, 2'd0, 8'h00, 1'b1, 1'b1, 8'h0B, 8'h0B, 8'h00, 8'h79};
    stim_table[16] = {3'd0, 1'b0, 2'd0, 8'h00, 1'b1, 1'b0, 8'h01, 8'h02, 8'h00, 8'h00};

    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // reset state
    check_value("data_out", 32'(data_out), 32'h0);
    check_value("awready", 32'(awready), 32'h0);
    check_value("wready", 32'(wready), 32'h0);
    check_value("bvalid", 32'(bvalid), 32'h0);
    check_value("rvalid", 32'(rvalid), 32'h0);
    for (int a = 0; a <= 8'h14; a += 4) begin
      read_and_compare(8'(a), 32'h0, RESP_OKAY);
    end

    // opcodes, operand selects and bypass from the table, then random rows
    for (int i = 0; i < NUM_FIXED; i++) begin
      apply_row(stim_table[i]);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      take_bits(3, r_op);
      take_bits(1, r_lsel);
      take_bits(2, r_rsel);
      take_bits(8, r_cnst);
      take_bits(1, r_byp);
      take_bits(8, r_in1);
      take_bits(8, r_in2);
      take_bits(8, r_in3);
      if (r_rsel[1:0] == 2'd3) r_rsel = 8'd2;   // feedback is covered by the accumulator.
      acc = model_result(r_op[2:0], r_lsel[0], r_rsel[1:0], r_cnst, 1'b1,
                         r_in1, r_in2, r_in3, 8'h00);
      apply_row({r_op[2:0], r_lsel[0], r_rsel[1:0], r_cnst, r_byp[0], 1'b1,
                 r_in1, r_in2, r_in3, acc});
    end

    // accumulation through the feedback path
    set_inputs(8'h00, 8'h00, 8'h00);
    write_reg(`CGRA_REG_MODE, 32'h0);
    write_reg(`CGRA_REG_SEL, 32'h4);
    write_reg(`CGRA_REG_CONST, 32'h0);
    write_reg(`CGRA_REG_OP, 32'(OP_AND));
    write_reg(`CGRA_REG_CTRL, 32'h1);   // in1 and 0 clears the register.
    write_reg(`CGRA_REG_OP, 32'(OP_ADD));
    write_reg(`CGRA_REG_SEL, 32'h6);
    acc = 8'h00;
    check_value("data_out", 32'(data_out), 32'(acc));
    for (int i = 0; i < 8; i++) begin
      take_bits(8, r_in1);
      data_in1 = r_in1;
      acc = model_result(3'd0, 1'b0, 2'd3, 8'h00, 1'b1, r_in1, 8'h00, 8'h00, acc);
      to_drive_slot();
      check_value("data_out", 32'(data_out), 32'(acc));
    end
    data_in1 = 8'h00;
    write_reg(`CGRA_REG_CTRL, 32'h0);
    data_in1 = 8'h5A;
    repeat (3) begin
      to_drive_slot();
      check_value("data_out", 32'(data_out), 32'(acc));   // disabled, so it holds.
    end
    axi_read(`CGRA_REG_RESULT, data, resp);
    check_value("rdata", data, 32'(acc));
    check_value("rresp", 32'(resp), 32'(RESP_OKAY));

    // byte strobes and illegal accesses
    write_reg(`CGRA_REG_CONST, 32'h000000A5);
    axi_write(`CGRA_REG_CONST, 32'h00000000, 4'b1110, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    read_and_compare(`CGRA_REG_CONST, 32'hA5, RESP_OKAY);
    axi_write(`CGRA_REG_SEL, 32'h00000007, 4'b0000, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    read_and_compare(`CGRA_REG_SEL, 32'h6, RESP_OKAY);
    axi_write(`CGRA_REG_SEL, 32'hFFFFFF05, 4'b0001, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    read_and_compare(`CGRA_REG_SEL, 32'h5, RESP_OKAY);
    axi_write(`CGRA_REG_RESULT, 32'h000000FF, 4'hF, resp);
    check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    read_and_compare(`CGRA_REG_RESULT, 32'(acc), RESP_OKAY);
    axi_write(8'h20, 32'h0000003C, 4'hF, resp);
    check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    read_and_compare(`CGRA_REG_CONST, 32'hA5, RESP_OKAY);
    read_and_compare(8'h20, 32'h0, RESP_SLVERR);

    // write response back-pressure
    bready = 1'b0;
    issue_write(`CGRA_REG_CONST, 32'h11, 4'hF);
    wait_bvalid(resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    to_drive_slot();
    awaddr  = `CGRA_REG_CONST;
    wdata   = 32'h22;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("bvalid", 32'(bvalid), 32'h1);
      check_value("awready", 32'(awready), 32'h0);
      check_value("wready", 32'(wready), 32'h0);
    end
    to_drive_slot();
    bready = 1'b1;
    issue_write(`CGRA_REG_CONST, 32'h22, 4'hF);
    wait_bvalid(resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    to_drive_slot();
    bready = 1'b0;
    read_and_compare(`CGRA_REG_CONST, 32'h22, RESP_OKAY);

    $display("closing: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
